// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_e         op,
    input  logic                    word_op,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    output logic [rv_pkg::XLEN-1:0] result
);
    import rv_pkg::*;

    logic [XLEN-1:0] shift_src;
    logic [5:0]      shamt;
    logic [XLEN-1:0] full;

    // word ops shift the low half only, sign-extended just for sra
    always_comb begin
        if (word_op) begin
            if (op == alu_sra) begin
                shift_src = {{32{a[31]}}, a[31:0]};
            end else begin
                shift_src = {32'b0, a[31:0]};
            end
            shamt = {1'b0, b[4:0]};
        end else begin
            shift_src = a;
            shamt     = b[5:0];
        end
    end

    always_comb begin
        case (op)
            alu_add:    full = a + b;
            alu_sub:    full = a - b;
            alu_slt:    full = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   full = {{(XLEN-1){1'b0}}, a < b};
            alu_xor:    full = a ^ b;
            alu_or:     full = a | b;
            alu_and:    full = a & b;
            alu_sll:    full = shift_src << shamt;
            alu_srl:    full = shift_src >> shamt;
            alu_sra:    full = $signed(shift_src) >>> shamt;
            alu_pass_b: full = b;
            default:    full = a + b;
        endcase
    end

    assign result = word_op ? {{32{full[31]}}, full[31:0]} : full; // w-ops sext the low word

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  rv_pkg::branch_e         kind,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    output logic [rv_pkg::XLEN-1:0] next_pc
);
    import rv_pkg::*;

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    always_comb begin
        case (kind)
            br_eq:   taken = eq;
            br_ne:   taken = !eq;
            br_lt:   taken = lt;
            br_ge:   taken = !lt;
            br_ltu:  taken = ltu;
            br_geu:  taken = !ltu;
            br_jal:  taken = 1'b1;
            default: taken = 1'b0; // none, jalr handled below
        endcase
    end

    always_comb begin
        if (kind == br_jalr) begin
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + XLEN'(4);
        end
    end

endmodule

// ==== data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_WORDS = 512
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic                    re,
    input  logic [rv_pkg::XLEN-1:0] addr,
    input  rv_pkg::mem_size_e       size,
    input  logic                    load_unsigned,
    input  logic [rv_pkg::XLEN-1:0] wdata,
    output logic [rv_pkg::XLEN-1:0] rdata
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [2:0]       offs;
    logic [7:0]       mask;
    logic [7:0]       lane_en;
    logic [XLEN-1:0]  wdata_sh;
    logic [XLEN-1:0]  shifted;

    assign idx = addr[IDX_W+2:3]; // upper bits dropped, address wraps

    // offset forced to natural alignment of the access
    always_comb begin
        case (size)
            size_b: begin
                offs = addr[2:0];
                mask = 8'h01;
            end
            size_h: begin
                offs = {addr[2:1], 1'b0};
                mask = 8'h03;
            end
            size_w: begin
                offs = {addr[2], 2'b00};
                mask = 8'h0f;
            end
            default: begin
                offs = 3'b000;
                mask = 8'hff;
            end
        endcase
    end

    assign lane_en  = mask << offs;
    assign wdata_sh = wdata << {offs, 3'b000};

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 8; i++) begin
                if (lane_en[i]) begin
                    mem[idx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
                end
            end
        end
    end

    assign shifted = mem[idx] >> {offs, 3'b000}; // addressed bytes down to lane 0

    always_comb begin
        if (!re) begin
            rdata = '0;
        end else begin
            case (size)
                size_b:  rdata = {{56{shifted[7] & !load_unsigned}}, shifted[7:0]};
                size_h:  rdata = {{48{shifted[15] & !load_unsigned}}, shifted[15:0]};
                size_w:  rdata = {{32{shifted[31] & !load_unsigned}}, shifted[31:0]};
                default: rdata = shifted;
            endcase
        end
    end

endmodule

// ==== exec_core.sv ====
`timescale 1ns/1ps

module exec_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC  = '0,
    parameter int                      MEM_WORDS = 512
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  logic [31:0]             inst,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    retire_valid,
    output logic [4:0]              retire_rd,
    output logic [rv_pkg::XLEN-1:0] retire_data,
    output logic                    retire_illegal,
    output logic                    halted
);
    import rv_pkg::*;

    alu_op_e         alu_op;
    src_a_e          src_a;
    src_b_e          src_b;
    branch_e         branch;
    mem_size_e       mem_size;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic            load_unsigned;
    logic            word_op;
    logic            illegal;
    logic            is_ebreak;

    logic            accept;
    logic            rf_we;
    logic            dm_we;
    logic            writes_rd;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] pc_plus4;

    assign accept    = inst_valid && !halted;
    assign rf_we     = accept && reg_write && !illegal;
    assign dm_we     = accept && mem_write && !illegal;
    assign writes_rd = rf_we && (rd != 5'd0);
    assign pc_plus4  = pc + XLEN'(4);

    inst_decoder i_inst_decoder (
        .inst          (inst),
        .alu_op        (alu_op),
        .src_a         (src_a),
        .src_b         (src_b),
        .branch        (branch),
        .mem_size      (mem_size),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .imm           (imm),
        .reg_write     (reg_write),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .load_unsigned (load_unsigned),
        .word_op       (word_op),
        .illegal       (illegal),
        .is_ebreak     (is_ebreak)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign op_a = (src_a == a_pc) ? pc : rs1_data;

    always_comb begin
        case (src_b)
            b_rs2:   op_b = rs2_data;
            b_imm:   op_b = imm;
            default: op_b = XLEN'(4);
        endcase
    end

    alu i_alu (
        .op      (alu_op),
        .word_op (word_op),
        .a       (op_a),
        .b       (op_b),
        .result  (alu_result)
    );

    branch_unit i_branch_unit (
        .kind       (branch),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .imm        (imm),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) i_data_mem (
        .clk           (clk),
        .we            (dm_we),
        .re            (mem_read),
        .addr          (alu_result),
        .size          (mem_size),
        .load_unsigned (load_unsigned),
        .wdata         (rs2_data),
        .rdata         (load_data)
    );

    // jalr uses the alu for its target, so its link comes from pc + 4
    always_comb begin
        if (mem_read) begin
            wb_data = load_data;
        end else if (branch == br_jalr) begin
            wb_data = pc_plus4;
        end else begin
            wb_data = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc             <= RESET_PC;
            retire_valid   <= 1'b0;
            retire_illegal <= 1'b0;
            halted         <= 1'b0;
        end else begin
            retire_valid <= accept;
            if (accept) begin
                pc             <= next_pc;
                retire_illegal <= illegal;
                if (is_ebreak) begin
                    halted <= 1'b1; // sticky until reset
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire_rd   <= writes_rd ? rd : 5'd0;
            retire_data <= writes_rd ? wb_data : '0;
        end
    end

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]        inst,
    output rv_pkg::alu_op_e    alu_op,
    output rv_pkg::src_a_e     src_a,
    output rv_pkg::src_b_e     src_b,
    output rv_pkg::branch_e    branch,
    output rv_pkg::mem_size_e  mem_size,
    output logic [4:0]         rd,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [63:0]        imm,
    output logic               reg_write,
    output logic               mem_read,
    output logic               mem_write,
    output logic               load_unsigned,
    output logic               word_op,
    output logic               illegal,
    output logic               is_ebreak
);
    import rv_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_u;
    logic [63:0] imm_j;

    // register/immediate arithmetic share the funct3 map, alt picks sub or sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        alu_op        = alu_add;
        src_a         = a_rs1;
        src_b         = b_imm;
        branch        = br_none;
        mem_size      = mem_size_e'(funct3[1:0]);
        imm           = imm_i;
        reg_write     = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        load_unsigned = 1'b0;
        word_op       = 1'b0;
        illegal       = 1'b0;
        is_ebreak     = 1'b0;

        case (opcode)
            op_lui: begin
                imm       = imm_u;
                alu_op    = alu_pass_b;
                reg_write = 1'b1;
            end
            op_auipc: begin
                imm       = imm_u;
                src_a     = a_pc;
                reg_write = 1'b1;
            end
            op_jal: begin
                imm       = imm_j;  // branch unit adds it to pc
                src_a     = a_pc;
                src_b     = b_four; // link value
                branch    = br_jal;
                reg_write = 1'b1;
            end
            op_jalr: begin
                branch    = br_jalr; // alu forms rs1 + imm as target
                reg_write = 1'b1;
                illegal   = (funct3 != 3'b000);
            end
            op_branch: begin
                imm   = imm_b;
                src_b = b_rs2;
                case (funct3)
                    3'b000:  branch = br_eq;
                    3'b001:  branch = br_ne;
                    3'b100:  branch = br_lt;
                    3'b101:  branch = br_ge;
                    3'b110:  branch = br_ltu;
                    3'b111:  branch = br_geu;
                    default: illegal = 1'b1;
                endcase
            end
            op_load: begin
                mem_read      = 1'b1;
                reg_write     = 1'b1;
                load_unsigned = funct3[2];
                illegal       = (funct3 == 3'b111); // no ldu
            end
            op_store: begin
                imm       = imm_s;
                mem_write = 1'b1;
                illegal   = funct3[2];
            end
            op_imm: begin
                reg_write = 1'b1;
                alu_op    = arith_op(funct3, inst[30] & (funct3 == 3'b101));
                // 6-bit shamt, so only inst[31:26] is funct
                if (funct3 == 3'b001) begin
                    illegal = (inst[31:26] != 6'b0);
                end else if (funct3 == 3'b101) begin
                    illegal = ({inst[31], inst[29:26]} != 5'b0);
                end
            end
            op_imm32: begin
                reg_write = 1'b1;
                word_op   = 1'b1;
                alu_op    = arith_op(funct3, inst[30] & (funct3 == 3'b101));
                case (funct3)
                    3'b000:  illegal = 1'b0;
                    3'b001:  illegal = (funct7 != 7'b0);
                    3'b101:  illegal = ({funct7[6], funct7[4:0]} != 6'b0);
                    default: illegal = 1'b1;
                endcase
            end
            op_reg: begin
                reg_write = 1'b1;
                src_b     = b_rs2;
                alu_op    = arith_op(funct3, funct7[5]);
                illegal   = ({funct7[6], funct7[4:0]} != 6'b0)
                         || (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101);
            end
            op_reg32: begin
                reg_write = 1'b1;
                word_op   = 1'b1;
                src_b     = b_rs2;
                alu_op    = arith_op(funct3, funct7[5]);
                illegal   = ({funct7[6], funct7[4:0]} != 6'b0)
                         || !(funct3 inside {3'b000, 3'b001, 3'b101})
                         || (funct7[5] && funct3 == 3'b001);
            end
            op_system: begin
                is_ebreak = (inst == 32'h0010_0073);
                illegal   = !is_ebreak; // csr, ecall, mret not supported
            end
            default: illegal = 1'b1;
        endcase

        // illegal instructions have no side effects and fall through to pc + 4
        if (illegal) begin
            reg_write = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
            branch    = br_none;
        end
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    we,
    input  logic [4:0]              waddr,
    input  logic [rv_pkg::XLEN-1:0] wdata,
    input  logic [4:0]              raddr1,
    input  logic [4:0]              raddr2,
    output logic [rv_pkg::XLEN-1:0] rdata1,
    output logic [rv_pkg::XLEN-1:0] rdata2
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

    parameter int XLEN = 64;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_imm32  = 7'b0011011,
        op_reg    = 7'b0110011,
        op_reg32  = 7'b0111011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b  // lui
    } alu_op_e;

    typedef enum logic {a_rs1, a_pc} src_a_e;

    typedef enum logic [1:0] {b_rs2, b_imm, b_four} src_b_e;

    typedef enum logic [3:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu,
        br_jal,
        br_jalr
    } branch_e;

    // same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {size_b, size_h, size_w, size_d} mem_size_e;

endpackage

// ==== sources.f ====
rv_pkg.sv
inst_decoder.sv
reg_file.sv
alu.sv
branch_unit.sv
data_mem.sv
exec_core.sv
tb_exec_core.sv

// ==== tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;
    import rv_pkg::*;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic [63:0] pc;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [63:0] retire_data;
    logic        retire_illegal;
    logic        halted;

    logic [63:0] shadow [32];      // reference register file
    logic [7:0]  mem_model [4096]; // reference data bytes
    logic [63:0] model_pc;
    integer      seed;

    exec_core #(
        .RESET_PC  (64'h0),
        .MEM_WORDS (512)
    ) i_exec_core (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal),
        .halted         (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input opcode_e op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
        input opcode_e op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // rv64i integer results, alt selects sub or sra
    function automatic logic [63:0] alu_model(input logic [2:0] f3, input logic alt,
        input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'b0, $signed(a) < $signed(b)};
            3'd3:    return {63'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [63:0] word_model(input logic [2:0] f3, input logic alt,
        input logic [63:0] a, input logic [63:0] b);
        logic [31:0] r;
        case (f3)
            3'd0:    r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'd1:    r = a[31:0] << b[4:0];
            default: begin
                if (alt) begin
                    r = $signed(a[31:0]) >>> b[4:0];
                end else begin
                    r = a[31:0] >> b[4:0];
                end
            end
        endcase
        return {{32{r[31]}}, r};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
        input logic [63:0] exp);
        $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        abort_run("unexpected value on a DUT output");
    endtask

    // one strobe, then the retire cycle is checked against the model
    task automatic issue(input logic [31:0] word, input logic [4:0] rd, input logic [63:0] value,
        input logic ill, input logic [63:0] exp_pc);
        logic [4:0]  exp_rd;
        logic [63:0] exp_data;
        int          cycles;
        exp_rd   = ill ? 5'd0 : rd;
        exp_data = (exp_rd == 5'd0) ? 64'd0 : value;
        inst       = word;
        inst_valid = 1'b1;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        cycles     = 0;
        while (!retire_valid && cycles < 16) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (retire_valid) else abort_run("timeout waiting for retire_valid");
        assert (retire_rd === exp_rd) else report_mismatch("retire_rd", retire_rd, exp_rd);
        assert (retire_data === exp_data) else report_mismatch("retire_data", retire_data, exp_data);
        assert (retire_illegal === ill) else report_mismatch("retire_illegal", retire_illegal, ill);
        assert (pc === exp_pc) else report_mismatch("pc", pc, exp_pc);
        if (exp_rd != 5'd0) shadow[exp_rd] = exp_data;
        model_pc = exp_pc;
    endtask

    task automatic exec_seq(input logic [31:0] word, input logic [4:0] rd, input logic [63:0] value);
        issue(word, rd, value, 1'b0, model_pc + 64'd4);
    endtask

    // lui + addiw gives any sign-extended 32-bit value
    task automatic put32(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] t;
        t = v + 32'h800;
        exec_seq(u_type(t[31:12], rd, op_lui), rd, {{32{t[31]}}, t[31:12], 12'h000});
        exec_seq(i_type(v[11:0], rd, 3'b000, rd, op_imm32), rd, {{32{v[31]}}, v});
    endtask

    task automatic load_value64(input logic [4:0] rd, input logic [63:0] v);
        put32(rd, v[63:32]);
        exec_seq(i_type(12'd32, rd, 3'b001, rd, op_imm), rd, {v[63:32], 32'h0});
        put32(5'd31, v[31:0]); // x31 is scratch
        exec_seq(i_type(12'd32, 31, 3'b001, 31, op_imm), 31, {v[31:0], 32'h0});
        exec_seq(i_type(12'd32, 31, 3'b101, 31, op_imm), 31, {32'h0, v[31:0]});
        exec_seq(r_type(7'h00, 31, rd, 3'b110, rd, op_reg), rd, v);
    endtask

    task automatic store_tracked(input logic [1:0] sz, input logic [4:0] src,
        input logic [11:0] off);
        logic [63:0] addr;
        addr = shadow[5] + sext12(off);
        issue(s_type(off, src, 5, {1'b0, sz}), 0, 0, 1'b0, model_pc + 64'd4);
        for (int i = 0; i < (1 << sz); i++) begin
            mem_model[addr[11:0] + i] = shadow[src][8*i +: 8];
        end
    endtask

    task automatic load_checked(input logic [1:0] sz, input logic uns, input logic [4:0] dst,
        input logic [11:0] off);
        logic [63:0] addr;
        logic [63:0] val;
        int          n;
        addr = shadow[5] + sext12(off);
        n    = 1 << sz;
        val  = '0;
        for (int i = 0; i < n; i++) val[8*i +: 8] = mem_model[addr[11:0] + i];
        if (!uns && val[8*n-1]) begin
            for (int i = n; i < 8; i++) val[8*i +: 8] = 8'hff; // sign fill
        end
        exec_seq(i_type(off, 5, {uns, sz}, dst, op_load), dst, val);
    endtask

    task automatic branch_checked(input logic [2:0] f3, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [12:0] off);
        logic [63:0] a;
        logic [63:0] b;
        logic        taken;
        a = shadow[rs1];
        b = shadow[rs2];
        case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = ($signed(a) >= $signed(b));
            3'd6:    taken = (a < b);
            default: taken = (a >= b);
        endcase
        issue(b_type(off, rs2, rs1, f3), 0, 0, 1'b0,
              taken ? model_pc + {{51{off[12]}}, off} : model_pc + 64'd4);
    endtask

    task automatic alu_ops_test();
        logic [63:0] a;
        logic [63:0] b;
        logic [11:0] imm;
        logic [5:0]  sh;
        logic [2:0]  f3;
        repeat (3) begin
            a   = {$random(seed), $random(seed)};
            b   = {$random(seed), $random(seed)};
            imm = $random(seed);
            sh  = $random(seed);
            load_value64(1, a);
            load_value64(2, b);
            for (int f = 0; f < 8; f++) begin
                f3 = f;
                exec_seq(r_type(7'h00, 2, 1, f3, 3, op_reg), 3, alu_model(f3, 1'b0, a, b));
                if (f3 == 3'd0 || f3 == 3'd5) begin
                    exec_seq(r_type(7'h20, 2, 1, f3, 3, op_reg), 3, alu_model(f3, 1'b1, a, b));
                end
                if (f3 != 3'd1 && f3 != 3'd5) begin
                    exec_seq(i_type(imm, 1, f3, 4, op_imm), 4, alu_model(f3, 1'b0, a, sext12(imm)));
                end
            end
            exec_seq(i_type({6'h00, sh}, 1, 3'd1, 4, op_imm), 4, alu_model(3'd1, 1'b0, a, sh));
            exec_seq(i_type({6'h00, sh}, 1, 3'd5, 4, op_imm), 4, alu_model(3'd5, 1'b0, a, sh));
            exec_seq(i_type({6'h10, sh}, 1, 3'd5, 4, op_imm), 4, alu_model(3'd5, 1'b1, a, sh));
            exec_seq(u_type(a[19:0], 4, op_auipc), 4,
                     model_pc + {{32{a[19]}}, a[19:0], 12'h000});
        end
    endtask

    task automatic word_ops_test();
        logic [63:0] a;
        logic [63:0] b;
        logic [11:0] imm;
        logic [4:0]  sh;
        repeat (3) begin
            a   = {$random(seed), $random(seed)};
            b   = {$random(seed), $random(seed)};
            imm = $random(seed);
            sh  = $random(seed);
            load_value64(1, a);
            load_value64(2, b);
            exec_seq(r_type(7'h00, 2, 1, 3'd0, 5, op_reg32), 5, word_model(3'd0, 1'b0, a, b));
            exec_seq(r_type(7'h20, 2, 1, 3'd0, 5, op_reg32), 5, word_model(3'd0, 1'b1, a, b));
            exec_seq(r_type(7'h00, 2, 1, 3'd1, 5, op_reg32), 5, word_model(3'd1, 1'b0, a, b));
            exec_seq(r_type(7'h00, 2, 1, 3'd5, 5, op_reg32), 5, word_model(3'd5, 1'b0, a, b));
            exec_seq(r_type(7'h20, 2, 1, 3'd5, 5, op_reg32), 5, word_model(3'd5, 1'b1, a, b));
            exec_seq(i_type(imm, 1, 3'd0, 6, op_imm32), 6, word_model(3'd0, 1'b0, a, sext12(imm)));
            exec_seq(i_type({7'h00, sh}, 1, 3'd1, 6, op_imm32), 6, word_model(3'd1, 1'b0, a, sh));
            exec_seq(i_type({7'h00, sh}, 1, 3'd5, 6, op_imm32), 6, word_model(3'd5, 1'b0, a, sh));
            exec_seq(i_type({7'h20, sh}, 1, 3'd5, 6, op_imm32), 6, word_model(3'd5, 1'b1, a, sh));
        end
    endtask

    task automatic mem_access_test();
        logic [1:0] sz;
        exec_seq(i_type(12'h100, 0, 3'd0, 5, op_imm), 5, 64'h100); // base in x5
        repeat (2) begin
            load_value64(6, {$random(seed), $random(seed)});
            load_value64(7, {$random(seed), $random(seed)});
            store_tracked(2'd3, 6, 12'h000);
            store_tracked(2'd3, 6, 12'h008);
            store_tracked(2'd3, 7, 12'hff8);
            store_tracked(2'd0, 7, 12'h003); // partial writes over the doublewords
            store_tracked(2'd1, 7, 12'h00a);
            store_tracked(2'd2, 7, 12'h004);
            store_tracked(2'd0, 7, 12'h00f);
            for (int s = 0; s < 4; s++) begin
                sz = s;
                for (int off = 0; off < 16; off += (1 << s)) begin
                    load_checked(sz, 1'b0, 8, off);
                    if (s != 3) load_checked(sz, 1'b1, 9, off);
                end
            end
            load_checked(2'd3, 1'b0, 8, 12'hff8);
        end
    endtask

    task automatic branch_jump_test();
        exec_seq(i_type(12'hffb, 0, 3'd0, 10, op_imm), 10, -64'sd5);
        exec_seq(i_type(12'h003, 0, 3'd0, 11, op_imm), 11, 64'd3);
        exec_seq(i_type(12'h200, 0, 3'd0, 12, op_imm), 12, 64'h200);
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                branch_checked(f, 10, 11, 13'd16);
                branch_checked(f, 11, 10, 13'h1ff8);  // backward offset
                branch_checked(f, 10, 10, 13'd24);
            end
        end
        issue(j_type(21'd32, 1), 1, model_pc + 64'd4, 1'b0, model_pc + 64'd32);
        issue(j_type(21'h1ffff4, 0), 0, 0, 1'b0, model_pc - 64'd12);
        issue(i_type(12'd5, 12, 3'd0, 3, op_jalr), 3, model_pc + 64'd4, 1'b0, 64'h204);
        issue(i_type(12'hffc, 12, 3'd0, 4, op_jalr), 4, model_pc + 64'd4, 1'b0, 64'h1fc);
    endtask

    task automatic x0_illegal_test();
        exec_seq(i_type(12'd123, 0, 3'd0, 0, op_imm), 0, 64'd123);
        exec_seq(u_type(20'h12345, 0, op_lui), 0, 64'h12345000);
        exec_seq(i_type(12'd7, 0, 3'd0, 13, op_imm), 13, 64'd7); // x0 still reads zero
        issue(r_type(7'h01, 3, 2, 3'd0, 1, op_reg), 1, 0, 1'b1, model_pc + 64'd4); // mul
        issue(32'hffff_ffff, 31, 0, 1'b1, model_pc + 64'd4);
        issue(i_type(12'd0, 5, 3'd7, 3, op_load), 3, 0, 1'b1, model_pc + 64'd4);
        issue(i_type(12'h800, 1, 3'd5, 4, op_imm), 4, 0, 1'b1, model_pc + 64'd4);
        // destinations of the illegal words keep their old values
        exec_seq(r_type(7'h00, 0, 1, 3'd0, 15, op_reg), 15, shadow[1]);
        exec_seq(r_type(7'h00, 0, 31, 3'd0, 16, op_reg), 16, shadow[31]);
        exec_seq(r_type(7'h00, 0, 3, 3'd0, 17, op_reg), 17, shadow[3]);
        exec_seq(r_type(7'h00, 0, 4, 3'd0, 18, op_reg), 18, shadow[4]);
    endtask

    task automatic ebreak_halt_test();
        int cycles;
        issue(32'h0010_0073, 0, 0, 1'b0, model_pc + 64'd4);
        assert (halted === 1'b1) else report_mismatch("halted", halted, 1'b1);
        inst   = i_type(12'd1, 0, 3'd0, 20, op_imm);
        cycles = 0;
        while (cycles < 8) begin
            inst_valid = (cycles < 3); // a few strobes while halted
            @(posedge clk);
            #1;
            assert (!retire_valid) else abort_run("retire_valid rose while the core was halted");
            cycles++;
        end
        inst_valid = 1'b0;
        assert (pc === model_pc) else report_mismatch("pc", pc, model_pc);
        assert (halted === 1'b1) else report_mismatch("halted", halted, 1'b1);
    endtask

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = 32'h0;
        seed       = 19;
        model_pc   = 64'h0;
        for (int i = 0; i < 32; i++) shadow[i] = 64'h0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (pc === 64'h0) else report_mismatch("pc", pc, 64'h0);
        assert (retire_valid === 1'b0) else report_mismatch("retire_valid", retire_valid, 1'b0);
        assert (retire_illegal === 1'b0)
            else report_mismatch("retire_illegal", retire_illegal, 1'b0);
        assert (halted === 1'b0) else report_mismatch("halted", halted, 1'b0);
        alu_ops_test();
        word_ops_test();
        mem_access_test();
        branch_jump_test();
        x0_illegal_test();
        ebreak_halt_test();
        $display("Verification passed");
        $finish;
    end

endmodule
